// File: all.f
rtl/cta_desc_pkg.sv
rtl/cta_table_pkg.sv
rtl/slot_allocator.sv
rtl/slot_store.sv
rtl/pop_buffer.sv
rtl/active_cta_table.sv
verif/tb_active_cta_table.sv

// File: rtl/active_cta_table.sv
`timescale 1ns/1ps

module active_cta_table (
    input  logic                                                  clk,
    input  logic                                                  rst_n,

    // Add request
    input  logic                                                  add_valid,
    input  cta_desc_pkg::cta_desc_t                               add_desc,
    output logic                                                  add_ready,

    // Pop request, names a slot
    input  logic                                                  pop_valid,
    input  cta_table_pkg::slot_idx_t                              pop_slot,

    // Popped descriptor
    output logic                                                  out_valid,
    output cta_desc_pkg::cta_desc_t                               out_desc,
    input  logic                                                  out_ready,

    // Status
    output logic [cta_table_pkg::NUM_SLOTS-1:0]                   cta_valid,
    output cta_desc_pkg::cta_desc_t [cta_table_pkg::NUM_SLOTS-1:0] cta_status,
    output logic                                                  full,
    output cta_table_pkg::slot_idx_t                              next_empty_slot
);
    import cta_desc_pkg::*;
    import cta_table_pkg::*;

    logic [NUM_SLOTS-1:0]   occupied;
    slot_idx_t              alloc_base;
    slot_cnt_t              alloc_span;
    logic                   add_fire;
    logic                   pop_hit;
    logic                   pop_take;
    cta_desc_t              pop_desc;

    assign add_fire = add_valid && add_ready;

    slot_allocator u_slot_allocator (
        .clk             (clk),
        .rst_n           (rst_n),
        .add_valid       (add_valid),
        .add_desc        (add_desc),
        .occupied        (occupied),
        .add_ready       (add_ready),
        .full            (full),
        .alloc_base      (alloc_base),
        .alloc_span      (alloc_span),
        .next_empty_slot (next_empty_slot)
    );

    slot_store u_slot_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .add_fire     (add_fire),
        .alloc_base   (alloc_base),
        .alloc_span   (alloc_span),
        .add_desc     (add_desc),
        .pop_valid    (pop_valid),
        .pop_slot     (pop_slot),
        .pop_take     (pop_take),
        .occupied     (occupied),
        .pop_hit      (pop_hit),
        .pop_desc     (pop_desc),
        .cta_valid    (cta_valid),
        .cta_status   (cta_status)
    );

    pop_buffer u_pop_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .pop_hit   (pop_hit),
        .pop_desc  (pop_desc),
        .pop_take  (pop_take),
        .out_valid (out_valid),
        .out_desc  (out_desc),
        .out_ready (out_ready)
    );

endmodule

// File: rtl/cta_desc_pkg.sv
package cta_desc_pkg;

    // Largest CTA a kernel may launch
    localparam int MAX_CTA_THREADS = 1024;

    // Field widths
    localparam int COORD_W      = 16;
    localparam int THREAD_CNT_W = $clog2(MAX_CTA_THREADS) + 1;
    localparam int KERNEL_ID_W  = 16;

    // One coordinate of the CTA id
    typedef logic [COORD_W-1:0] cta_coord_t;

    // Thread count, wide enough to hold MAX_CTA_THREADS itself
    typedef logic [THREAD_CNT_W-1:0] thread_count_t;

    typedef logic [KERNEL_ID_W-1:0] kernel_id_t;

    // Descriptor carried on add, on the output port and in the status view
    typedef struct packed {
        cta_coord_t    id_x;
        cta_coord_t    id_y;
        cta_coord_t    id_z;
        thread_count_t size;
        kernel_id_t    kernel_id;
    } cta_desc_t;

endpackage

// File: rtl/cta_table_pkg.sv
package cta_table_pkg;

    localparam int NUM_SLOTS = 4;

    // Slot width is derived from its log, so it is always a power of two
    localparam int SLOT_THREADS_LOG2 = 8;
    localparam int SLOT_THREADS      = 1 << SLOT_THREADS_LOG2;
    localparam int TABLE_THREADS     = NUM_SLOTS * SLOT_THREADS;

    localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);
    // Span must be able to hold NUM_SLOTS itself
    localparam int SLOT_CNT_W = $clog2(NUM_SLOTS + 1);

    typedef logic [SLOT_IDX_W-1:0] slot_idx_t;
    typedef logic [SLOT_CNT_W-1:0] slot_cnt_t;

    // Stored entry; only the primary slot of a CTA carries the descriptor
    typedef struct packed {
        logic                    valid;
        logic                    is_primary;
        slot_cnt_t               span;
        cta_desc_pkg::cta_desc_t desc;
    } slot_entry_t;

    // Slots covered by a run of span slots starting at base
    function automatic logic [NUM_SLOTS-1:0] slot_run_mask(slot_idx_t base, slot_cnt_t span);
        logic [NUM_SLOTS-1:0] mask;
        mask = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            mask[i] = (i >= int'(base)) && (i < int'(base) + int'(span));
        end
        return mask;
    endfunction

endpackage

// File: rtl/pop_buffer.sv
`timescale 1ns/1ps

module pop_buffer (
    input  logic                    clk,
    input  logic                    rst_n,

    // From the slot store
    input  logic                    pop_hit,
    input  cta_desc_pkg::cta_desc_t pop_desc,
    output logic                    pop_take,

    // Output port
    output logic                    out_valid,
    output cta_desc_pkg::cta_desc_t out_desc,
    input  logic                    out_ready
);
    import cta_desc_pkg::*;

    logic       drain;
    cta_desc_t  desc_q;

    assign drain = out_valid && out_ready;

    // Room exists when empty or when the held entry leaves this cycle
    assign pop_take = pop_hit && (!out_valid || out_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            desc_q    <= '0;
        end else begin
            if (pop_take) begin
                // Also covers drain plus new pop, valid stays up
                out_valid <= 1'b1;
                desc_q    <= pop_desc;
            end else if (drain) begin
                out_valid <= 1'b0;
                desc_q    <= '0;
            end
        end
    end

    assign out_desc = desc_q;

    // Held descriptor must not move under back-pressure
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_desc))
        else $error("out_desc changed while stalled");

endmodule

// File: rtl/slot_allocator.sv
`timescale 1ns/1ps

module slot_allocator (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 add_valid,
    input  cta_desc_pkg::cta_desc_t              add_desc,
    input  logic [cta_table_pkg::NUM_SLOTS-1:0]  occupied,
    output logic                                 add_ready,
    output logic                                 full,
    output cta_table_pkg::slot_idx_t             alloc_base,
    output cta_table_pkg::slot_cnt_t             alloc_span,
    output cta_table_pkg::slot_idx_t             next_empty_slot
);
    import cta_desc_pkg::*;
    import cta_table_pkg::*;

    slot_idx_t               first_free;
    logic [THREAD_CNT_W:0]   size_rounded;
    logic                    add_taken;

    // Lowest free slot wins
    always_comb begin
        first_free = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                first_free = slot_idx_t'(i);
            end
        end
    end

    // Ceiling of size over slot width, one extra bit keeps the add from wrapping
    assign size_rounded = {1'b0, add_desc.size} + (THREAD_CNT_W + 1)'(SLOT_THREADS - 1);
    assign alloc_span   = slot_cnt_t'(size_rounded >> SLOT_THREADS_LOG2);

    assign full            = &occupied;
    assign add_ready       = !full;
    assign alloc_base      = first_free;
    assign next_empty_slot = first_free;

    assign add_taken = add_valid && add_ready;

    // Upstream only sends requests that fit; these catch a broken producer
    a_size_range: assert property (@(posedge clk) disable iff (!rst_n)
        add_taken |-> (add_desc.size != '0) && (int'(add_desc.size) <= TABLE_THREADS))
        else $error("CTA size %0d outside 1..%0d", add_desc.size, TABLE_THREADS);

    a_run_in_table: assert property (@(posedge clk) disable iff (!rst_n)
        add_taken |-> (int'(alloc_base) + int'(alloc_span) <= NUM_SLOTS))
        else $error("run of %0d slots at %0d overruns the table", alloc_span, alloc_base);

    a_run_free: assert property (@(posedge clk) disable iff (!rst_n)
        add_taken |-> ((slot_run_mask(alloc_base, alloc_span) & occupied) == '0))
        else $error("run of %0d slots at %0d overlaps busy slots %b",
                    alloc_span, alloc_base, occupied);

endmodule

// File: rtl/slot_store.sv
`timescale 1ns/1ps

module slot_store (
    input  logic                                                  clk,
    input  logic                                                  rst_n,

    // Allocation from the allocator
    input  logic                                                  add_fire,
    input  cta_table_pkg::slot_idx_t                              alloc_base,
    input  cta_table_pkg::slot_cnt_t                              alloc_span,
    input  cta_desc_pkg::cta_desc_t                               add_desc,

    // Pop request and release
    input  logic                                                  pop_valid,
    input  cta_table_pkg::slot_idx_t                              pop_slot,
    input  logic                                                  pop_take,

    output logic [cta_table_pkg::NUM_SLOTS-1:0]                   occupied,
    output logic                                                  pop_hit,
    output cta_desc_pkg::cta_desc_t                               pop_desc,

    // Status view
    output logic [cta_table_pkg::NUM_SLOTS-1:0]                   cta_valid,
    output cta_desc_pkg::cta_desc_t [cta_table_pkg::NUM_SLOTS-1:0] cta_status
);
    import cta_desc_pkg::*;
    import cta_table_pkg::*;

    slot_entry_t            slot_q [NUM_SLOTS];

    logic [NUM_SLOTS-1:0]   alloc_mask;
    logic [NUM_SLOTS-1:0]   release_mask;
    slot_entry_t            pop_entry;

    assign pop_entry = slot_q[pop_slot];

    // Only a primary slot can start a release, so a pop never clears half a CTA
    assign pop_hit  = pop_valid && pop_entry.valid && pop_entry.is_primary;
    assign pop_desc = pop_entry.desc;

    always_comb begin
        alloc_mask   = '0;
        release_mask = '0;
        if (add_fire) begin
            alloc_mask = slot_run_mask(alloc_base, alloc_span);
        end
        if (pop_take) begin
            release_mask = slot_run_mask(pop_slot, pop_entry.span);
        end
    end

    // Add and pop in the same cycle touch disjoint slots, so order is free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slot_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (release_mask[i]) begin
                    slot_q[i] <= '0;
                end else if (alloc_mask[i]) begin
                    slot_q[i].valid      <= 1'b1;
                    slot_q[i].is_primary <= (i == int'(alloc_base));
                    slot_q[i].span       <= alloc_span;
                    // Continuation slots keep the span only
                    if (i == int'(alloc_base)) begin
                        slot_q[i].desc <= add_desc;
                    end else begin
                        slot_q[i].desc <= '0;
                    end
                end
            end
        end
    end

    // Status shows one entry per CTA, at its primary slot
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            occupied[i]  = slot_q[i].valid;
            cta_valid[i] = slot_q[i].valid && slot_q[i].is_primary;
            if (cta_valid[i]) begin
                cta_status[i] = slot_q[i].desc;
            end else begin
                cta_status[i] = '0;
            end
        end
    end

    // Buffer must never accept a pop the table did not match
    a_take_needs_hit: assert property (@(posedge clk) disable iff (!rst_n)
        pop_take |-> pop_hit)
        else $error("pop_take on slot %0d without a primary hit", pop_slot);

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the active CTA table testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_active_cta_table \
    -f all.f -o sim_tb

output=$(./obj_dir/sim_tb)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

// File: verif/tb_active_cta_table.sv
`timescale 1ns/1ps

module tb_active_cta_table;
    import cta_desc_pkg::*;
    import cta_table_pkg::*;

    localparam int TIMEOUT_CYCLES = 3000;
    localparam int RANDOM_CYCLES  = 500;

    logic                             clk = 1'b0;
    logic                             rst_n;
    logic                             add_valid;
    cta_desc_t                        add_desc;
    logic                             add_ready;
    logic                             pop_valid;
    slot_idx_t                        pop_slot;
    logic                             out_valid;
    cta_desc_t                        out_desc;
    logic                             out_ready;
    logic [NUM_SLOTS-1:0]             cta_valid;
    cta_desc_t [NUM_SLOTS-1:0]        cta_status;
    logic                             full;
    slot_idx_t                        next_empty_slot;

    // Reference model of the table and the output buffer
    slot_entry_t                      m_slot [NUM_SLOTS];
    logic                             m_out_valid;
    cta_desc_t                        m_out_desc;
    logic [NUM_SLOTS-1:0]             exp_valid;
    cta_desc_t [NUM_SLOTS-1:0]        exp_status;
    logic                             exp_full;
    slot_idx_t                        exp_first;

    logic [31:0]                      lfsr = 32'hcc1025d7;
    int                               errors = 0;
    int                               cycle_count = 0;

    active_cta_table u_active_cta_table (
        .clk             (clk),
        .rst_n           (rst_n),
        .add_valid       (add_valid),
        .add_desc        (add_desc),
        .add_ready       (add_ready),
        .pop_valid       (pop_valid),
        .pop_slot        (pop_slot),
        .out_valid       (out_valid),
        .out_desc        (out_desc),
        .out_ready       (out_ready),
        .cta_valid       (cta_valid),
        .cta_status      (cta_status),
        .full            (full),
        .next_empty_slot (next_empty_slot)
    );

    always #20 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per returned bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[14:0], fb};
        end
        return val;
    endfunction

    function automatic cta_desc_t make_desc(input int size);
        cta_desc_t d;
        d.id_x      = rand_bits(16);
        d.id_y      = rand_bits(16);
        d.id_z      = rand_bits(16);
        d.size      = thread_count_t'(size);
        d.kernel_id = rand_bits(16);
        return d;
    endfunction

    // Length of the free run that starts at the lowest free slot
    function automatic int free_run();
        int   run;
        logic stop;
        run  = 0;
        stop = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (i >= int'(exp_first) && !stop) begin
                if (m_slot[i].valid) begin
                    stop = 1'b1;
                end else begin
                    run++;
                end
            end
        end
        return run;
    endfunction

    // Drives one cycle from the current falling edge to the next
    task automatic drive(input logic av, input int size, input logic pv, input int ps,
                         input logic rdy);
        add_valid = av;
        add_desc  = make_desc(size);
        pop_valid = pv;
        pop_slot  = slot_idx_t'(ps);
        out_ready = rdy;
        @(negedge clk);
    endtask

    always_comb begin
        exp_first = '0;
        exp_full  = 1'b1;
        // Full until the scan meets a free slot, which is then the lowest one
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (!m_slot[i].valid && exp_full) begin
                exp_first = slot_idx_t'(i);
                exp_full  = 1'b0;
            end
        end
        for (int i = 0; i < NUM_SLOTS; i++) begin
            exp_valid[i]  = m_slot[i].valid && m_slot[i].is_primary;
            exp_status[i] = exp_valid[i] ? m_slot[i].desc : '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        int   span;
        int   rel_span;
        logic pop_ok;
        logic add_ok;
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                m_slot[i] <= '0;
            end
            m_out_valid <= 1'b0;
            m_out_desc  <= '0;
        end else begin
            pop_ok   = pop_valid && m_slot[pop_slot].valid && m_slot[pop_slot].is_primary
                       && (!m_out_valid || out_ready);
            add_ok   = add_valid && !exp_full;
            span     = (int'(add_desc.size) + SLOT_THREADS - 1) / SLOT_THREADS;
            rel_span = int'(m_slot[pop_slot].span);
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (pop_ok && i >= int'(pop_slot) && i < int'(pop_slot) + rel_span) begin
                    m_slot[i] <= '0;
                end else if (add_ok && i >= int'(exp_first) && i < int'(exp_first) + span) begin
                    m_slot[i].valid      <= 1'b1;
                    m_slot[i].is_primary <= (i == int'(exp_first));
                    m_slot[i].span       <= slot_cnt_t'(span);
                    m_slot[i].desc       <= (i == int'(exp_first)) ? add_desc : '0;
                end
            end
            if (pop_ok) begin
                m_out_valid <= 1'b1;
                m_out_desc  <= m_slot[pop_slot].desc;
            end else if (m_out_valid && out_ready) begin
                m_out_valid <= 1'b0;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk) disable iff (!rst_n)
        (cycle_count == 0) |-> (!out_valid && cta_valid == '0 && !full && add_ready
                                && next_empty_slot == '0))
        else begin
            errors++;
            $display("Fail %0t: outputs not at reset values", $time);
        end

    a_cta_valid: assert property (@(posedge clk) disable iff (!rst_n) cta_valid == exp_valid)
        else begin
            errors++;
            $display("Fail %0t: cta_valid %b expected %b", $time, cta_valid, exp_valid);
        end

    a_cta_status: assert property (@(posedge clk) disable iff (!rst_n) cta_status == exp_status)
        else begin
            errors++;
            $display("Fail %0t: cta_status %h expected %h", $time, cta_status, exp_status);
        end

    a_full: assert property (@(posedge clk) disable iff (!rst_n)
        full == exp_full && add_ready == !exp_full)
        else begin
            errors++;
            $display("Fail %0t: full %b add_ready %b expected full %b", $time, full,
                     add_ready, exp_full);
        end

    a_next_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !exp_full |-> next_empty_slot == exp_first)
        else begin
            errors++;
            $display("Fail %0t: next_empty_slot %0d expected %0d", $time, next_empty_slot,
                     exp_first);
        end

    a_out_valid: assert property (@(posedge clk) disable iff (!rst_n) out_valid == m_out_valid)
        else begin
            errors++;
            $display("Fail %0t: out_valid %b expected %b", $time, out_valid, m_out_valid);
        end

    a_out_desc: assert property (@(posedge clk) disable iff (!rst_n)
        m_out_valid |-> out_desc == m_out_desc)
        else begin
            errors++;
            $display("Fail %0t: out_desc %h expected %h", $time, out_desc, m_out_desc);
        end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_desc))
        else begin
            errors++;
            $display("Fail %0t: out_desc moved under back-pressure", $time);
        end

    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("Simulation FAILED");
                $finish;
            end
        end
    end

    initial begin
        int size;
        int run;
        rst_n     = 1'b0;
        add_valid = 1'b0;
        add_desc  = '0;
        pop_valid = 1'b0;
        pop_slot  = '0;
        out_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        drive(1'b0, 1, 1'b0, 0, 1'b1);
        // Sizes 1, 257 and 256 fill the table
        drive(1'b1, 1, 1'b0, 0, 1'b1);
        drive(1'b1, 257, 1'b0, 0, 1'b1);
        drive(1'b1, 256, 1'b0, 0, 1'b1);
        drive(1'b1, 1, 1'b0, 0, 1'b1);
        // Non-primary pop, then the primary, then the freed slot
        drive(1'b0, 1, 1'b1, 2, 1'b1);
        drive(1'b0, 1, 1'b1, 1, 1'b1);
        drive(1'b0, 1, 1'b0, 0, 1'b1);
        drive(1'b0, 1, 1'b1, 1, 1'b1);
        drive(1'b1, 300, 1'b0, 0, 1'b1);
        // Stall the buffer, pops behind it must wait
        drive(1'b0, 1, 1'b1, 0, 1'b0);
        repeat (3) drive(1'b0, 1, 1'b1, 3, 1'b0);
        // Drain and replace in the same cycle, twice
        drive(1'b0, 1, 1'b1, 3, 1'b1);
        drive(1'b0, 1, 1'b1, 1, 1'b1);
        drive(1'b0, 1, 1'b0, 0, 1'b1);
        drive(1'b1, 1024, 1'b0, 0, 1'b1);
        drive(1'b0, 1, 1'b1, 2, 1'b1);
        drive(1'b0, 1, 1'b1, 0, 1'b1);
        drive(1'b0, 1, 1'b0, 0, 1'b1);
        repeat (RANDOM_CYCLES) begin
            run  = free_run();
            size = (run == 0) ? 1 : (int'(rand_bits(10)) % (run * SLOT_THREADS)) + 1;
            drive(rand_bits(1) != 0, size, rand_bits(1) != 0, int'(rand_bits(2)),
                  rand_bits(2) != 0);
        end
        drive(1'b0, 1, 1'b0, 0, 1'b1);
        drive(1'b0, 1, 1'b0, 0, 1'b1);
        $display("Run finished after %0d cycles with %0d errors", cycle_count, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
